// File: hdl/ex_cfg_pkg.sv
package ex_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath sizing
    ////////////////////////////////////////////////////////////////////////////

    // Default data width of one MIPS word
    localparam int NBITS = 32;

    // Register index width
    // Also the shamt field width
    localparam int RNBITS = 5;

    // ALU operation code width
    localparam int BOP = 4;

endpackage

// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction field widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int OPW = 6;                 // Opcode field, bits 31:26
    localparam int FNW = 6;                 // Funct field, bits 5:0

    // Result for any undefined ALU code
    // Wide enough for every data width the stage is built with
    localparam logic [63:0] ALU_ERR = {64{1'b1}};

    ////////////////////////////////////////////////////////////////////////////
    // ALU operation codes
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [ex_cfg_pkg::BOP-1:0] {
        ALU_AND = 4'b0000,                  // A and B
        ALU_OR  = 4'b0001,                  // A or B
        ALU_ADD = 4'b0010,                  // A + B
        ALU_SLL = 4'b0011,                  // B << shamt
        ALU_SRL = 4'b0100,                  // B >> shamt
        ALU_SUB = 4'b0110,                  // A - B
        ALU_SLT = 4'b0111,                  // Signed A < B
        ALU_SRA = 4'b1001,                  // B >>> shamt
        ALU_NOR = 4'b1100,                  // ~(A | B)
        ALU_XOR = 4'b1101,                  // A ^ B
        ALU_BAD = 4'b1111                   // Not decoded by the ALU
    } alu_op_e;

    // Coarse class from the main decoder
    typedef enum logic [1:0] {
        CLS_MEM    = 2'b00,                 // Load/store address add
        CLS_BRANCH = 2'b01,                 // Compare by subtract
        CLS_RTYPE  = 2'b10,                 // Look at funct
        CLS_ITYPE  = 2'b11                  // Look at opcode
    } alu_class_e;

    typedef enum logic [OPW-1:0] {
        OP_RTYPE = 6'b000000,
        OP_BEQ   = 6'b000100,
        OP_ADDI  = 6'b001000,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    typedef enum logic [FNW-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,                // Shift by rs
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,                // No trap, same datapath
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010
    } funct_e;

endpackage

// File: hdl/alu_control.sv
`timescale 1ns/1ps

module alu_control
    (
        input  mips_isa_pkg::alu_class_e             i_alu_class,  // From main decoder
        input  logic [mips_isa_pkg::FNW-1:0]         i_funct,      // R-type funct
        input  logic [mips_isa_pkg::OPW-1:0]         i_opcode,     // I-type opcode
        output mips_isa_pkg::alu_op_e                o_alu_op,
        output logic                                 o_shift_var   // Shift amount from rs
    );

    import mips_isa_pkg::*;

    // Second level of the two-level MIPS decode
    always_comb
    begin
        o_alu_op    = ALU_BAD;              // Unknown codes fall through to ALU_ERR
        o_shift_var = 1'b0;
        case (i_alu_class)
            CLS_MEM:    o_alu_op = ALU_ADD; // Base + offset
            CLS_BRANCH: o_alu_op = ALU_SUB; // Zero flag means equal
            CLS_RTYPE:
            begin
                case (i_funct)
                    FN_AND:              o_alu_op = ALU_AND;
                    FN_OR:               o_alu_op = ALU_OR;
                    FN_ADD, FN_ADDU:     o_alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU:     o_alu_op = ALU_SUB;
                    FN_SLT:              o_alu_op = ALU_SLT;
                    FN_NOR:              o_alu_op = ALU_NOR;
                    FN_XOR:              o_alu_op = ALU_XOR;
                    FN_SLL, FN_SLLV:     o_alu_op = ALU_SLL;
                    FN_SRL, FN_SRLV:     o_alu_op = ALU_SRL;
                    FN_SRA, FN_SRAV:     o_alu_op = ALU_SRA;
                    default:             o_alu_op = ALU_BAD;
                endcase
                // Variable forms take the amount from rs
                if (i_funct == FN_SLLV || i_funct == FN_SRLV || i_funct == FN_SRAV)
                begin
                    o_shift_var = 1'b1;
                end
            end
            CLS_ITYPE:
            begin
                case (i_opcode)
                    OP_ADDI:             o_alu_op = ALU_ADD;
                    OP_SLTI:             o_alu_op = ALU_SLT;
                    OP_ANDI:             o_alu_op = ALU_AND;
                    OP_ORI:              o_alu_op = ALU_OR;
                    OP_XORI:             o_alu_op = ALU_XOR;
                    OP_LW, OP_SW:        o_alu_op = ALU_ADD;  // Address add
                    OP_BEQ:              o_alu_op = ALU_SUB;  // Compare
                    default:             o_alu_op = ALU_BAD;  // OP_RTYPE lands here too
                endcase
            end
        endcase
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu
    #(
        parameter int NBITS  = ex_cfg_pkg::NBITS,
        parameter int RNBITS = ex_cfg_pkg::RNBITS
    )
    (
        input  logic [NBITS-1:0]       i_reg,      // Operand A, forwarded rs
        input  logic [NBITS-1:0]       i_mux,      // Operand B, rt or immediate
        input  logic [RNBITS-1:0]      i_shamt,    // Shift amount
        input  mips_isa_pkg::alu_op_e  i_op,
        output logic                   o_zero,     // Result is zero
        output logic [NBITS-1:0]       o_result
    );

    import mips_isa_pkg::*;

    logic [NBITS-1:0] result;
    logic             lt_signed;

    ////////////////////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////////////////////

    // Two's complement less-than for SLT/SLTI
    assign lt_signed = $signed(i_reg) < $signed(i_mux);

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (i_op)
            ALU_AND:    result = i_reg & i_mux;
            ALU_OR:     result = i_reg | i_mux;
            ALU_ADD:    result = i_reg + i_mux;             // No overflow trap
            ALU_SUB:    result = i_reg - i_mux;
            ALU_SLT:
            begin
                result    = '0;
                result[0] = lt_signed;                      // 0 or 1
            end
            ALU_NOR:    result = ~(i_reg | i_mux);
            ALU_XOR:    result = i_reg ^ i_mux;

            // Shifts act on operand B only
            ALU_SLL:    result = i_mux << i_shamt;
            ALU_SRL:    result = i_mux >> i_shamt;          // Zero fill
            ALU_SRA:    result = $signed(i_mux) >>> i_shamt; // Sign fill

            default:    result = ALU_ERR[NBITS-1:0];        // All ones
        endcase
    end

    assign o_result = result;
    assign o_zero   = (result == '0);                       // Used by BEQ in MEM stage

endmodule

// File: hdl/forward_unit.sv
`timescale 1ns/1ps

module forward_unit
    #(
        parameter int NBITS  = ex_cfg_pkg::NBITS,
        parameter int RNBITS = ex_cfg_pkg::RNBITS
    )
    (
        input  logic [RNBITS-1:0] i_rs_idx,    // Sources of this instruction
        input  logic [RNBITS-1:0] i_rt_idx,
        input  logic [RNBITS-1:0] i_exm_rd,    // Previous instruction, EX/MEM
        input  logic [RNBITS-1:0] i_wb_rd,     // Older instruction, write-back
        input  logic              i_exm_we,
        input  logic              i_wb_we,
        input  logic [NBITS-1:0]  i_rs_data,   // Register file values
        input  logic [NBITS-1:0]  i_rt_data,
        input  logic [NBITS-1:0]  i_exm_data,
        input  logic [NBITS-1:0]  i_wb_data,
        output logic [NBITS-1:0]  o_rs_fwd,
        output logic [NBITS-1:0]  o_rt_fwd
    );

    // One source operand, newest producer first
    function automatic logic [NBITS-1:0] pick
        (
            input logic [RNBITS-1:0] idx,
            input logic [NBITS-1:0]  reg_data
        );
        logic exm_hit;
        logic wb_hit;
        exm_hit = i_exm_we && (i_exm_rd != '0) && (i_exm_rd == idx);
        wb_hit  = i_wb_we  && (i_wb_rd  != '0) && (i_wb_rd  == idx);
        if (exm_hit)
        begin
            pick = i_exm_data;              // Most recent write wins
        end
        else if (wb_hit)
        begin
            pick = i_wb_data;
        end
        else
        begin
            pick = reg_data;                // $zero always ends up here
        end
    endfunction

    assign o_rs_fwd = pick(i_rs_idx, i_rs_data);
    assign o_rt_fwd = pick(i_rt_idx, i_rt_data);

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
    #(
        parameter int NBITS  = ex_cfg_pkg::NBITS,
        parameter int RNBITS = ex_cfg_pkg::RNBITS
    )
    (
        input  logic                          i_clk,
        input  logic                          i_rst_n,
        // Pipeline control from hazard logic
        input  logic                          i_stall,      // Level, freezes EX/MEM
        input  logic                          i_flush,      // Pulse, loads a bubble
        input  logic                          i_valid,
        // ID/EX values
        input  mips_isa_pkg::alu_class_e      i_alu_class,
        input  logic [mips_isa_pkg::FNW-1:0]  i_funct,
        input  logic [mips_isa_pkg::OPW-1:0]  i_opcode,
        input  logic                          i_alu_src,    // 1 selects immediate
        input  logic                          i_reg_dst,    // 1 selects rd
        input  logic                          i_reg_we,
        input  logic [RNBITS-1:0]             i_rs_idx,
        input  logic [RNBITS-1:0]             i_rt_idx,
        input  logic [RNBITS-1:0]             i_rd_idx,
        input  logic [RNBITS-1:0]             i_shamt,
        input  logic [NBITS-1:0]              i_rs_data,
        input  logic [NBITS-1:0]              i_rt_data,
        input  logic [NBITS-1:0]              i_imm,        // Already sign extended
        // Write-back path
        input  logic [RNBITS-1:0]             i_wb_rd,
        input  logic                          i_wb_we,
        input  logic [NBITS-1:0]              i_wb_data,
        // EX/MEM register
        output logic                          o_valid,
        output logic [NBITS-1:0]              o_result,
        output logic                          o_zero,
        output logic [NBITS-1:0]              o_store_data, // Forwarded rt for SW
        output logic [RNBITS-1:0]             o_dest,
        output logic                          o_reg_we
    );

    import mips_isa_pkg::*;

    logic [NBITS-1:0]  rs_fwd;
    logic [NBITS-1:0]  rt_fwd;
    logic [NBITS-1:0]  alu_b;
    logic [RNBITS-1:0] shamt;
    logic [RNBITS-1:0] dest;
    logic [NBITS-1:0]  alu_result;
    logic              alu_zero;
    logic              shift_var;
    alu_op_e           alu_op;

    ////////////////////////////////////////////////////////////////////////////
    // Operand path
    ////////////////////////////////////////////////////////////////////////////

    // EX/MEM contents feed straight back, no bubble for back-to-back use
    forward_unit #(.NBITS(NBITS), .RNBITS(RNBITS)) u_fwd (
        .i_rs_idx   (i_rs_idx),
        .i_rt_idx   (i_rt_idx),
        .i_exm_rd   (o_dest),
        .i_wb_rd    (i_wb_rd),
        .i_exm_we   (o_reg_we),
        .i_wb_we    (i_wb_we),
        .i_rs_data  (i_rs_data),
        .i_rt_data  (i_rt_data),
        .i_exm_data (o_result),
        .i_wb_data  (i_wb_data),
        .o_rs_fwd   (rs_fwd),
        .o_rt_fwd   (rt_fwd)
    );

    alu_control u_alu_ctl (
        .i_alu_class (i_alu_class),
        .i_funct     (i_funct),
        .i_opcode    (i_opcode),
        .o_alu_op    (alu_op),
        .o_shift_var (shift_var)
    );

    assign alu_b = i_alu_src ? i_imm : rt_fwd;
    assign shamt = shift_var ? rs_fwd[RNBITS-1:0] : i_shamt;  // SLLV/SRLV/SRAV use rs
    assign dest  = i_reg_dst ? i_rd_idx : i_rt_idx;           // rd for R-type

    alu #(.NBITS(NBITS), .RNBITS(RNBITS)) u_alu (
        .i_reg    (rs_fwd),
        .i_mux    (alu_b),
        .i_shamt  (shamt),
        .i_op     (alu_op),
        .o_zero   (alu_zero),
        .o_result (alu_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid      <= 1'b0;
            o_reg_we     <= 1'b0;
            o_result     <= '0;
            o_zero       <= 1'b0;
            o_store_data <= '0;
            o_dest       <= '0;
        end
        else if (!i_stall)                  // Stall holds everything, beats flush
        begin
            if (i_flush)
            begin
                o_valid      <= 1'b0;       // Bubble
                o_reg_we     <= 1'b0;
                o_result     <= '0;
                o_zero       <= 1'b0;
                o_store_data <= '0;
                o_dest       <= '0;
            end
            else
            begin
                o_valid      <= i_valid;
                o_reg_we     <= i_reg_we & i_valid;  // Invalid slot never writes
                o_result     <= alu_result;
                o_zero       <= alu_zero;
                o_store_data <= rt_fwd;
                o_dest       <= dest;
            end
        end
    end

endmodule

// File: sim/tb_ex_vectors.svh
// Columns: name, class, funct, opcode, {alu_src, reg_dst, reg_we}, rs, rt, rd, shamt,
//          rs data, rt data, immediate, {rnd, valid, flush, stall}, wb rd, wb we, wb data
task automatic build_table();
    nv = 0;
    // Register-register ALU ops
    add_vec("add",        CLS_RTYPE, FN_ADD,  OP_RTYPE, 3'b011, 1, 2, 3, 0, 15, 27, 0, C_N, 0, 0, 0);
    add_vec("sub_fwd",    CLS_RTYPE, FN_SUB,  OP_RTYPE, 3'b011, 3, 2, 4, 0, 0, 27, 0, C_N, 0, 0, 0);
    add_vec("and_rnd",    CLS_RTYPE, FN_AND,  OP_RTYPE, 3'b011, 6, 7, 8, 0, 0, 0, 0, C_R, 0, 0, 0);
    add_vec("or_rnd",     CLS_RTYPE, FN_OR,   OP_RTYPE, 3'b011, 6, 7, 9, 0, 0, 0, 0, C_R, 0, 0, 0);
    add_vec("xor_rnd",    CLS_RTYPE, FN_XOR,  OP_RTYPE, 3'b011, 6, 7, 10, 0, 0, 0, 0, C_R, 0, 0, 0);
    add_vec("nor_rnd",    CLS_RTYPE, FN_NOR,  OP_RTYPE, 3'b011, 6, 7, 11, 0, 0, 0, 0, C_R, 0, 0, 0);
    add_vec("slt_neg",    CLS_RTYPE, FN_SLT,  OP_RTYPE, 3'b011, 12, 13, 14, 0, 'hfffffffb, 3, 0, C_N,
            0, 0, 0);
    add_vec("slt_zero",   CLS_RTYPE, FN_SLT,  OP_RTYPE, 3'b011, 12, 13, 15, 0, 3, 'hfffffffb, 0, C_N,
            0, 0, 0);
    // Shifts, fixed then variable
    add_vec("sll",        CLS_RTYPE, FN_SLL,  OP_RTYPE, 3'b011, 0, 13, 16, 4, 0, 'hf1, 0, C_N, 0, 0, 0);
    add_vec("srl",        CLS_RTYPE, FN_SRL,  OP_RTYPE, 3'b011, 0, 13, 17, 8, 0, 'h8000ff00, 0, C_N,
            0, 0, 0);
    add_vec("sra",        CLS_RTYPE, FN_SRA,  OP_RTYPE, 3'b011, 0, 13, 18, 8, 0, 'h8000ff00, 0, C_N,
            0, 0, 0);
    add_vec("sllv",       CLS_RTYPE, FN_SLLV, OP_RTYPE, 3'b011, 12, 13, 19, 0, 'hffffffe3, 1, 0, C_N,
            0, 0, 0);
    add_vec("srlv_rnd",   CLS_RTYPE, FN_SRLV, OP_RTYPE, 3'b011, 12, 13, 22, 0, 0, 0, 0, C_R, 0, 0, 0);
    add_vec("srav",       CLS_RTYPE, FN_SRAV, OP_RTYPE, 3'b011, 12, 13, 23, 0, 31, 'h80000000, 0, C_N,
            0, 0, 0);
    add_vec("addu_rnd",   CLS_RTYPE, FN_ADDU, OP_RTYPE, 3'b011, 6, 7, 24, 0, 0, 0, 0, C_R, 0, 0, 0);
    add_vec("subu_eq",    CLS_RTYPE, FN_SUBU, OP_RTYPE, 3'b011, 6, 7, 25, 0, 55, 55, 0, C_N, 0, 0, 0);
    // Immediate forms
    add_vec("addi",       CLS_ITYPE, FN_SLL, OP_ADDI, 3'b101, 6, 26, 0, 0, 100, 0, 'hfffffff0, C_N,
            0, 0, 0);
    add_vec("slti",       CLS_ITYPE, FN_SLL, OP_SLTI, 3'b101, 6, 27, 0, 0, 'hfffffff0, 0, 0, C_N,
            0, 0, 0);
    add_vec("andi_rnd",   CLS_ITYPE, FN_SLL, OP_ANDI, 3'b101, 6, 28, 0, 0, 0, 0, 'hffff, C_R, 0, 0, 0);
    add_vec("ori_rnd",    CLS_ITYPE, FN_SLL, OP_ORI,  3'b101, 6, 29, 0, 0, 0, 0, 'h1234, C_R, 0, 0, 0);
    add_vec("xori_rnd",   CLS_ITYPE, FN_SLL, OP_XORI, 3'b101, 6, 30, 0, 0, 0, 0, 'hffff0000, C_R,
            0, 0, 0);
    // Address add and compare
    add_vec("lw",         CLS_MEM, FN_SLL, OP_LW, 3'b101, 6, 31, 0, 0, 1000, 0, 8, C_N, 0, 0, 0);
    add_vec("sw",         CLS_MEM, FN_SLL, OP_SW, 3'b100, 6, 7, 0, 0, 1000, 'hdead, 'hfffffffc, C_N,
            0, 0, 0);
    add_vec("beq_eq",     CLS_BRANCH, FN_SLL, OP_BEQ, 3'b000, 6, 7, 0, 0, 7, 7, 0, C_N, 0, 0, 0);
    add_vec("beq_ne",     CLS_BRANCH, FN_SLL, OP_BEQ, 3'b000, 6, 7, 0, 0, 7, 9, 0, C_N, 0, 0, 0);
    // Forwarding paths
    add_vec("wb_fwd",     CLS_RTYPE, FN_OR,  OP_RTYPE, 3'b011, 20, 0, 21, 0, 1, 0, 0, C_N, 20, 1, 'h1234);
    add_vec("exm_prio",   CLS_RTYPE, FN_ADD, OP_RTYPE, 3'b011, 21, 2, 5, 0, 0, 1, 0, C_N, 21, 1, 'hbad);
    add_vec("zero_write", CLS_RTYPE, FN_ADD, OP_RTYPE, 3'b011, 1, 2, 0, 0, 5, 6, 0, C_N, 0, 0, 0);
    add_vec("zero_nofwd", CLS_RTYPE, FN_ADD, OP_RTYPE, 3'b011, 0, 0, 7, 0, 0, 0, 0, C_N, 0, 1, 'h77);
    // Pipeline control
    add_vec("stall",      CLS_RTYPE, FN_XOR, OP_RTYPE, 3'b011, 1, 2, 8, 0, 'hff, 'h0f, 0, C_S, 0, 0, 0);
    add_vec("flush",      CLS_RTYPE, FN_XOR, OP_RTYPE, 3'b011, 1, 2, 8, 0, 'hff, 'h0f, 0, C_F, 0, 0, 0);
    add_vec("invalid",    CLS_RTYPE, FN_ADD, OP_RTYPE, 3'b011, 1, 2, 9, 0, 1, 2, 0, C_I, 0, 0, 0);
    add_vec("bad_funct",  CLS_RTYPE, 6'b111111, OP_RTYPE, 3'b001, 1, 2, 3, 0, 1, 2, 0, C_N, 0, 0, 0);
endtask

// File: sim/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    import mips_isa_pkg::*;

    localparam int NBITS  = ex_cfg_pkg::NBITS;
    localparam int RNBITS = ex_cfg_pkg::RNBITS;
    localparam int NVEC   = 33;                 // Entries in tb_ex_vectors.svh
    localparam logic [3:0] C_N = 4'b0100;       // Plain valid instruction
    localparam logic [3:0] C_R = 4'b1100;       // Random rs/rt data
    localparam logic [3:0] C_S = 4'b0101;       // Stall
    localparam logic [3:0] C_F = 4'b0110;       // Flush
    localparam logic [3:0] C_I = 4'b0000;       // Invalid slot

    logic i_clk = 1'b0;
    logic i_rst_n, i_stall, i_flush, i_valid, i_alu_src, i_reg_dst, i_reg_we, i_wb_we;
    alu_class_e i_alu_class;
    logic [5:0] i_funct, i_opcode;
    logic [RNBITS-1:0] i_rs_idx, i_rt_idx, i_rd_idx, i_shamt, i_wb_rd;
    logic [NBITS-1:0]  i_rs_data, i_rt_data, i_imm, i_wb_data;
    logic o_valid, o_zero, o_reg_we;
    logic [NBITS-1:0]  o_result, o_store_data;
    logic [RNBITS-1:0] o_dest;

    // Vector table storage
    string             v_name [NVEC];
    alu_class_e        v_cls  [NVEC];
    logic [5:0]        v_fn   [NVEC];
    logic [5:0]        v_op   [NVEC];
    logic [2:0]        v_sel  [NVEC];
    logic [RNBITS-1:0] v_rs [NVEC], v_rt [NVEC], v_rd [NVEC], v_sh [NVEC], v_wbrd [NVEC];
    logic [NBITS-1:0]  v_a [NVEC], v_b [NVEC], v_imm [NVEC], v_wbd [NVEC];
    logic [3:0]        v_ctl  [NVEC];
    logic              v_wbwe [NVEC];
    int nv;

    // Model of EX/MEM contents
    logic m_valid, m_zero, m_we;
    logic [NBITS-1:0]  m_result, m_store;
    logic [RNBITS-1:0] m_dest;
    int errors, test_errs, failed_tests;

    always #4 i_clk = ~i_clk;                   // 8 ns period

    ex_stage #(.NBITS(NBITS), .RNBITS(RNBITS)) UUT (.*);

    task automatic add_vec(input string name, input alu_class_e cls, input logic [5:0] fn,
                           input logic [5:0] op, input logic [2:0] sel,
                           input logic [RNBITS-1:0] rs, input logic [RNBITS-1:0] rt,
                           input logic [RNBITS-1:0] rd, input logic [RNBITS-1:0] sh,
                           input logic [NBITS-1:0] a, input logic [NBITS-1:0] b,
                           input logic [NBITS-1:0] imm, input logic [3:0] ctl,
                           input logic [RNBITS-1:0] wbrd, input logic wbwe,
                           input logic [NBITS-1:0] wbd);
        v_name[nv] = name;
        v_cls[nv]  = cls;
        v_fn[nv]   = fn;
        v_op[nv]   = op;
        v_sel[nv]  = sel;
        v_rs[nv]   = rs;
        v_rt[nv]   = rt;
        v_rd[nv]   = rd;
        v_sh[nv]   = sh;
        v_a[nv]    = a;
        v_b[nv]    = b;
        v_imm[nv]  = imm;
        v_ctl[nv]  = ctl;
        v_wbrd[nv] = wbrd;
        v_wbwe[nv] = wbwe;
        v_wbd[nv]  = wbd;
        nv++;
    endtask

    `include "tb_ex_vectors.svh"

    task automatic check_result(input string what, input logic [NBITS-1:0] got,
                                input logic [NBITS-1:0] exp);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_dest(input string what, input logic [RNBITS-1:0] got,
                              input logic [RNBITS-1:0] exp);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
            test_errs++;
        end
    endtask

    // Newest producer wins and register 0 never forwards
    function automatic logic [NBITS-1:0] fwd_value(input logic [RNBITS-1:0] idx,
                                                   input logic [NBITS-1:0] reg_data);
        if (m_we && m_dest != 0 && m_dest == idx)
            return m_result;
        if (i_wb_we && i_wb_rd != 0 && i_wb_rd == idx)
            return i_wb_data;
        return reg_data;
    endfunction

    // ALU result following the instruction set rules
    function automatic logic [NBITS-1:0] ref_alu(input alu_class_e cls, input logic [5:0] fn,
                                                 input logic [5:0] op, input logic [NBITS-1:0] a,
                                                 input logic [NBITS-1:0] b,
                                                 input logic [RNBITS-1:0] sh);
        logic [RNBITS-1:0] va;
        va = a[RNBITS-1:0];                     // Variable shift amount
        if (cls == CLS_MEM)
            return a + b;
        if (cls == CLS_BRANCH)
            return a - b;
        if (cls == CLS_RTYPE)
        begin
            case (fn)
                FN_ADD, FN_ADDU: return a + b;
                FN_SUB, FN_SUBU: return a - b;
                FN_AND:  return a & b;
                FN_OR:   return a | b;
                FN_XOR:  return a ^ b;
                FN_NOR:  return ~(a | b);
                FN_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
                FN_SLL:  return b << sh;
                FN_SRL:  return b >> sh;
                FN_SRA:  return $signed(b) >>> sh;
                FN_SLLV: return b << va;
                FN_SRLV: return b >> va;
                FN_SRAV: return $signed(b) >>> va;
                default: return ALU_ERR[NBITS-1:0];
            endcase
        end
        case (op)
            OP_ADDI, OP_LW, OP_SW: return a + b;
            OP_SLTI: return ($signed(a) < $signed(b)) ? 1 : 0;
            OP_ANDI: return a & b;
            OP_ORI:  return a | b;
            OP_XORI: return a ^ b;
            OP_BEQ:  return a - b;
            default: return ALU_ERR[NBITS-1:0];
        endcase
    endfunction

    task automatic check_outputs(input string name);
        check_flag({name, " o_valid"}, o_valid, m_valid);
        check_flag({name, " o_reg_we"}, o_reg_we, m_we);
        check_flag({name, " o_zero"}, o_zero, m_zero);
        check_result({name, " o_result"}, o_result, m_result);
        check_result({name, " o_store_data"}, o_store_data, m_store);
        check_dest({name, " o_dest"}, o_dest, m_dest);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        #((NVEC + 20) * 8);
        $display("Error: simulation timed out before all vectors were applied");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        logic [NBITS-1:0] a, b, rs_f, rt_f, res;
        void'($urandom(32'h47dc7ca6));
        {i_stall, i_flush, i_valid, i_alu_src, i_reg_dst, i_reg_we, i_wb_we} = '0;
        i_alu_class = CLS_MEM;
        {i_funct, i_opcode, i_rs_idx, i_rt_idx, i_rd_idx, i_shamt, i_wb_rd} = '0;
        {i_rs_data, i_rt_data, i_imm, i_wb_data} = '0;
        {m_valid, m_zero, m_we, m_result, m_store, m_dest} = '0;
        errors = 0;
        failed_tests = 0;
        build_table();
        if (nv != NVEC)
        begin
            $display("Error: vector table holds %0d entries, expected %0d", nv, NVEC);
            errors++;
        end
        i_rst_n = 1'b0;
        repeat (10) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        test_errs = 0;
        check_outputs("reset");                 // All zero out of reset
        $display("Test reset: %s", (test_errs == 0) ? "ok" : "mismatch");
        errors += test_errs;
        failed_tests += (test_errs != 0);
        for (int i = 0; i < NVEC; i++)
        begin
            a = v_ctl[i][3] ? $urandom : v_a[i];
            b = v_ctl[i][3] ? $urandom : v_b[i];
            i_alu_class = v_cls[i];
            i_funct     = v_fn[i];
            i_opcode    = v_op[i];
            {i_alu_src, i_reg_dst, i_reg_we} = v_sel[i];
            i_rs_idx    = v_rs[i];
            i_rt_idx    = v_rt[i];
            i_rd_idx    = v_rd[i];
            i_shamt     = v_sh[i];
            i_rs_data   = a;
            i_rt_data   = b;
            i_imm       = v_imm[i];
            i_valid     = v_ctl[i][2];
            i_flush     = v_ctl[i][1];
            i_stall     = v_ctl[i][0];
            i_wb_rd     = v_wbrd[i];
            i_wb_we     = v_wbwe[i];
            i_wb_data   = v_wbd[i];
            rs_f = fwd_value(i_rs_idx, a);
            rt_f = fwd_value(i_rt_idx, b);
            res  = ref_alu(v_cls[i], v_fn[i], v_op[i], rs_f, i_alu_src ? i_imm : rt_f, i_shamt);
            @(posedge i_clk);
            #1;
            if (i_stall)
            begin
                // EX/MEM held as it was
            end
            else if (i_flush)
            begin
                {m_valid, m_zero, m_we, m_result, m_store, m_dest} = '0;
            end
            else
            begin
                m_valid  = i_valid;
                m_we     = i_reg_we & i_valid;
                m_result = res;
                m_zero   = (res == 0);
                m_store  = rt_f;
                m_dest   = i_reg_dst ? i_rd_idx : i_rt_idx;
            end
            test_errs = 0;
            check_outputs(v_name[i]);
            $display("Test %0d %s: %s", i, v_name[i], (test_errs == 0) ? "ok" : "mismatch");
            errors += test_errs;
            failed_tests += (test_errs != 0);
        end
        $display("Summary: %0d tests, %0d failed, %0d check errors", NVEC + 1, failed_tests,
                 errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+sim
hdl/ex_cfg_pkg.sv
hdl/mips_isa_pkg.sv
hdl/alu_control.sv
hdl/alu.sv
hdl/forward_unit.sv
hdl/ex_stage.sv
sim/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - hdl/ex_cfg_pkg.sv
  - hdl/mips_isa_pkg.sv
  - hdl/alu_control.sv
  - hdl/alu.sv
  - hdl/forward_unit.sv
  - hdl/ex_stage.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_ex_stage.sv
